/* mister_rom_loader.f */
logic/loader_pkg.sv
logic/load_link_if.sv
logic/dwnld_capture.sv
logic/load_fifo.sv
logic/prog_writer.sv
logic/mister_rom_loader.sv
testbench/tb_mister_rom_loader.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_mister_rom_loader
FILELIST  := mister_rom_loader.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_mister_rom_loader.sv */
`timescale 1ns/1ps

module tb_mister_rom_loader;

    localparam int ROWS           = 24;
    localparam int TIMEOUT_CYCLES = ROWS * 16 + 100;

    logic                    clk_rom;
    logic                    arst_n;
    logic                    hps_download;
    logic                    hps_wr;
    loader_pkg::dwnld_idx_t  hps_index;
    loader_pkg::hps_addr_t   hps_addr;
    loader_pkg::hps_byte_t   hps_dout;
    logic                    hps_wait;
    logic                    prog_rdy;
    logic                    prog_we;
    loader_pkg::sdram_addr_t prog_addr;
    loader_pkg::prog_data_t  prog_data;
    loader_pkg::prog_mask_t  prog_mask;
    logic                    downloading;

    // Stimulus table, one host strobe per row
    loader_pkg::dwnld_idx_t tbl_index [ROWS];
    loader_pkg::hps_addr_t  tbl_addr  [ROWS];
    loader_pkg::hps_byte_t  tbl_data  [ROWS];
    logic                   tbl_write [ROWS];

    // Rows expected to reach the SDRAM, in table order
    int   exp_rows [$];
    int   n_flagged    = 0;
    int   write_count  = 0;
    int   write_done   = 0;
    int   wait_cycles  = 0;
    int   cycle_count  = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    logic dl_watch;

    int err_reset = 0;
    int err_data  = 0;
    int err_count = 0;
    int err_hold  = 0;
    int err_flow  = 0;
    int err_dl    = 0;
    int err_tail  = 0;

    mister_rom_loader u_dut (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .hps_download ( hps_download ),
        .hps_wr       ( hps_wr       ),
        .hps_index    ( hps_index    ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .hps_wait     ( hps_wait     ),
        .prog_rdy     ( prog_rdy     ),
        .prog_we      ( prog_we      ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .prog_mask    ( prog_mask    ),
        .downloading  ( downloading  )
    );

    initial begin
        clk_rom = 1'b0;
        forever begin
            #5 clk_rom = ~clk_rom;
        end
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic set_row(input int i, input loader_pkg::dwnld_idx_t idx,
                           input loader_pkg::hps_addr_t addr,
                           input loader_pkg::hps_byte_t data, input logic wr);
        tbl_index[i] = idx;
        tbl_addr[i]  = addr;
        tbl_data[i]  = data;
        tbl_write[i] = wr;
    endtask

    task automatic load_table();
        // Plain ROM bytes, both lanes of a few words
        set_row(0,  8'd0,   27'h0000000, 8'h11, 1'b1);
        set_row(1,  8'd0,   27'h0000001, 8'h22, 1'b1);
        set_row(2,  8'd0,   27'h0000002, 8'h33, 1'b1);
        set_row(3,  8'd0,   27'h0000003, 8'h44, 1'b1);
        set_row(4,  8'd0,   27'h0000010, 8'ha5, 1'b1);
        set_row(5,  8'd0,   27'h0000011, 8'h5a, 1'b1);
        set_row(6,  8'd0,   27'h0001235, 8'hc3, 1'b1);
        set_row(7,  8'd0,   27'h001fffe, 8'h3c, 1'b1);
        set_row(8,  8'd0,   27'h02aaaab, 8'h96, 1'b1);
        set_row(9,  8'd0,   27'h0155554, 8'h69, 1'b1);
        // Other file indexes mixed in
        set_row(10, 8'd1,   27'h0000020, 8'hde, 1'b0);
        set_row(11, 8'd0,   27'h0000020, 8'had, 1'b1);
        set_row(12, 8'd3,   27'h0000021, 8'hbe, 1'b0);
        // Edge of the programming space, 2**23 bytes
        set_row(13, 8'd0,   27'h07fffff, 8'hef, 1'b1);
        set_row(14, 8'd0,   27'h0800000, 8'h01, 1'b0);
        set_row(15, 8'd0,   27'h07ffffe, 8'hfe, 1'b1);
        set_row(16, 8'd0,   27'h0800001, 8'h02, 1'b0);
        set_row(17, 8'd0,   27'h7ffffff, 8'h03, 1'b0);
        set_row(18, 8'hff,  27'h0000100, 8'h04, 1'b0);
        set_row(19, 8'd0,   27'h0000100, 8'h80, 1'b1);
        set_row(20, 8'd0,   27'h0000101, 8'h7f, 1'b1);
        set_row(21, 8'd0,   27'h4000000, 8'h05, 1'b0);
        set_row(22, 8'd2,   27'h0000102, 8'h06, 1'b0);
        set_row(23, 8'd0,   27'h03fffff, 8'h00, 1'b1);
        for (int i = 0; i < ROWS; i++) begin
            if (tbl_write[i]) begin
                exp_rows.push_back(i);
            end
        end
        n_flagged = exp_rows.size();
    endtask

    task automatic send_row(input int i);
        // Let the previous byte reach the queue count before looking at wait
        @(posedge clk_rom);
        @(negedge clk_rom);
        while (hps_wait) begin
            @(negedge clk_rom);
        end
        @(posedge clk_rom);
        hps_wr    <= 1'b1;
        hps_index <= tbl_index[i];
        hps_addr  <= tbl_addr[i];
        hps_dout  <= tbl_data[i];
        @(posedge clk_rom);
        hps_wr <= 1'b0;
    endtask

    task automatic check_write(input int row, input loader_pkg::sdram_addr_t addr,
                               input loader_pkg::prog_data_t data,
                               input loader_pkg::prog_mask_t mask);
        loader_pkg::sdram_addr_t exp_addr;
        loader_pkg::prog_data_t  exp_data;
        loader_pkg::prog_mask_t  exp_mask;
        // Byte select bit dropped, byte copied to both lanes
        exp_addr = loader_pkg::sdram_addr_t'(tbl_addr[row] >> 1);
        exp_data = {tbl_data[row], tbl_data[row]};
        // Only the lane picked by the byte select bit is enabled (active low)
        exp_mask = 2'b11;
        exp_mask[tbl_addr[row][0]] = 1'b0;
        if (addr !== exp_addr) begin
            $display("Fail at %0t: prog_addr expected %h got %h (row %0d)",
                     $time, exp_addr, addr, row);
            err_data++;
        end
        if (data !== exp_data) begin
            $display("Fail at %0t: prog_data expected %h got %h (row %0d)",
                     $time, exp_data, data, row);
            err_data++;
        end
        if (mask !== exp_mask) begin
            $display("Fail at %0t: prog_mask expected %b got %b (row %0d)",
                     $time, exp_mask, mask, row);
            err_data++;
        end
    endtask

    task automatic check_held(input loader_pkg::sdram_addr_t addr,
                              input loader_pkg::prog_data_t data,
                              input loader_pkg::prog_mask_t mask);
        if (!prog_we || prog_addr !== addr || prog_data !== data || prog_mask !== mask) begin
            $display("Write request dropped or changed at %0t before prog_rdy", $time);
            err_hold++;
        end
    endtask

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors);
        end
    endtask

    // SDRAM programming port with a random answer delay
    initial begin : sdram_model
        loader_pkg::sdram_addr_t w_addr;
        loader_pkg::prog_data_t  w_data;
        loader_pkg::prog_mask_t  w_mask;
        logic [31:0]             rng_state;
        int                      delay;
        int                      sb_idx;
        prog_rdy  <= 1'b0;
        rng_state = 32'h1f7;
        sb_idx    = 0;
        forever begin
            @(posedge clk_rom);
            if (prog_we) begin
                w_addr = prog_addr;
                w_data = prog_data;
                w_mask = prog_mask;
                write_count <= write_count + 1;
                if (sb_idx < exp_rows.size()) begin
                    check_write(exp_rows[sb_idx], w_addr, w_data, w_mask);
                end else begin
                    $display("Write to word %h at %0t has no table row left to match",
                             w_addr, $time);
                    err_count++;
                end
                sb_idx++;
                rng_state = next_rand(rng_state);
                delay     = int'(rng_state[2:0]);
                repeat (delay) begin
                    @(posedge clk_rom);
                    check_held(w_addr, w_data, w_mask);
                end
                prog_rdy <= 1'b1;
                @(posedge clk_rom);
                check_held(w_addr, w_data, w_mask);
                prog_rdy   <= 1'b0;
                write_done <= write_done + 1;
                @(posedge clk_rom);
                if (prog_we) begin
                    $display("prog_we still high at %0t one cycle after prog_rdy", $time);
                    err_hold++;
                end
            end
        end
    end

    // Host rule, wait level and downloading flag, sampled every cycle
    always @(posedge clk_rom) begin
        if (arst_n) begin
            if (hps_wait) begin
                wait_cycles <= wait_cycles + 1;
            end
            if (hps_wait && hps_wr) begin
                $display("Host strobe issued at %0t while hps_wait was high", $time);
                err_flow <= err_flow + 1;
            end
            if (dl_watch && write_done < n_flagged && downloading !== 1'b1) begin
                $display("Fail at %0t: downloading expected 1 got %b", $time, downloading);
                err_dl <= err_dl + 1;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_rom);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d writes done",
                 cycle_count, write_done, n_flagged);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        arst_n       <= 1'b0;
        hps_download <= 1'b0;
        hps_wr       <= 1'b0;
        hps_index    <= '0;
        hps_addr     <= '0;
        hps_dout     <= '0;
        dl_watch     <= 1'b0;
        load_table();
        repeat (2) @(posedge clk_rom);
        arst_n <= 1'b1;

        @(negedge clk_rom);
        if (prog_we !== 1'b0) begin
            $display("Fail at %0t: prog_we expected 0 got %b", $time, prog_we);
            err_reset++;
        end
        if (hps_wait !== 1'b0) begin
            $display("Fail at %0t: hps_wait expected 0 got %b", $time, hps_wait);
            err_reset++;
        end
        if (downloading !== 1'b0) begin
            $display("Fail at %0t: downloading expected 0 got %b", $time, downloading);
            err_reset++;
        end
        report_test("reset_idle", err_reset);

        @(posedge clk_rom);
        hps_download <= 1'b1;
        repeat (3) @(posedge clk_rom);
        dl_watch <= 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            send_row(i);
        end
        @(posedge clk_rom);
        hps_download <= 1'b0;
        while (write_done < n_flagged) begin
            @(posedge clk_rom);
        end
        report_test("write_contents", err_data);
        if (wait_cycles == 0) begin
            $display("hps_wait never went high, the queue did not fill");
            err_flow++;
        end
        report_test("back_pressure", err_flow + err_hold);

        // Flag must drop after the last write and stay low
        repeat (2) @(posedge clk_rom);
        repeat (10) begin
            @(posedge clk_rom);
            if (downloading !== 1'b0) begin
                $display("Fail at %0t: downloading expected 0 got %b", $time, downloading);
                err_tail++;
            end
        end
        if (write_count != n_flagged) begin
            $display("Fail at %0t: write count expected %0d got %0d",
                     $time, n_flagged, write_count);
            err_count++;
        end
        report_test("dropped_bytes", err_count);
        report_test("downloading_flag", err_dl + err_tail);

        $display("Tests run %0d, passed %0d, failed %0d, writes %0d of %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 write_count, n_flagged);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* logic/mister_rom_loader.sv */
`timescale 1ns/1ps

module mister_rom_loader (
    input  logic                    clk_rom,
    input  logic                    arst_n,
    // Host I/O bridge
    input  logic                    hps_download,
    input  logic                    hps_wr,
    input  loader_pkg::dwnld_idx_t  hps_index,
    input  loader_pkg::hps_addr_t   hps_addr,
    input  loader_pkg::hps_byte_t   hps_dout,
    output logic                    hps_wait,
    // SDRAM programming port
    input  logic                    prog_rdy,
    output logic                    prog_we,
    output loader_pkg::sdram_addr_t prog_addr,
    output loader_pkg::prog_data_t  prog_data,
    output loader_pkg::prog_mask_t  prog_mask,
    output logic                    downloading
);

    load_link_if link_in ();
    load_link_if link_out ();

    dwnld_capture u_capture (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .hps_download ( hps_download ),
        .hps_wr       ( hps_wr       ),
        .hps_index    ( hps_index    ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .hps_wait     ( hps_wait     ),
        .link         ( link_in      )
    );

    // Absorbs SDRAM latency
    load_fifo u_fifo (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .link_in      ( link_in      ),
        .link_out     ( link_out     )
    );

    prog_writer u_writer (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .link         ( link_out     ),
        .prog_rdy     ( prog_rdy     ),
        .prog_we      ( prog_we      ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .prog_mask    ( prog_mask    ),
        .downloading  ( downloading  )
    );

endmodule

/* logic/prog_writer.sv */
`timescale 1ns/1ps

module prog_writer (
    input  logic                    clk_rom,
    input  logic                    arst_n,
    load_link_if.sink               link,
    input  logic                    prog_rdy,
    output logic                    prog_we,
    output loader_pkg::sdram_addr_t prog_addr,
    output loader_pkg::prog_data_t  prog_data,
    output loader_pkg::prog_mask_t  prog_mask,
    output logic                    downloading
);

    loader_pkg::wr_state_e state;
    logic                  busy;

    assign busy = (state != loader_pkg::WR_IDLE);

    // FSM
    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            state <= loader_pkg::WR_IDLE;
        end else begin
            case (state)
                loader_pkg::WR_IDLE: begin
                    if (link.stb) begin
                        state <= loader_pkg::WR_ISSUE;
                    end
                end
                loader_pkg::WR_ISSUE: begin
                    // A fast memory may answer in the first cycle
                    if (prog_rdy) begin
                        state <= loader_pkg::WR_IDLE;
                    end else begin
                        state <= loader_pkg::WR_WAIT;
                    end
                end
                loader_pkg::WR_WAIT: begin
                    if (prog_rdy) begin
                        state <= loader_pkg::WR_IDLE;
                    end
                end
                default: begin
                    state <= loader_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // Programming word, stable while prog_we is high
    always_ff @(posedge clk_rom) begin
        if (!busy && link.stb) begin
            prog_addr <= link.word_addr;
            prog_data <= {link.data, link.data};
            prog_mask <= link.mask;
        end
    end

    assign prog_we = (state == loader_pkg::WR_ISSUE) || (state == loader_pkg::WR_WAIT);

    // One entry at a time
    assign link.hold = busy;

    // Covers bytes still upstream and the write in progress
    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            downloading <= 1'b0;
        end else begin
            downloading <= link.open | busy;
        end
    end

    // Memory only answers a write that is pending
    assert property (@(posedge clk_rom) disable iff (!arst_n)
        prog_rdy |-> prog_we)
        else $error("prog_rdy without a pending write");

endmodule

/* logic/load_fifo.sv */
`timescale 1ns/1ps

module load_fifo (
    input  logic        clk_rom,
    input  logic        arst_n,
    load_link_if.sink   link_in,
    load_link_if.source link_out
);

    loader_pkg::sdram_addr_t addr_mem [loader_pkg::FIFO_DEPTH];
    loader_pkg::hps_byte_t   data_mem [loader_pkg::FIFO_DEPTH];
    loader_pkg::prog_mask_t  mask_mem [loader_pkg::FIFO_DEPTH];

    loader_pkg::fifo_ptr_t       wr_ptr;
    loader_pkg::fifo_ptr_t       rd_ptr;
    logic [loader_pkg::FIFO_PW:0] count;
    logic                        push;
    logic                        pop;
    logic                        empty;

    assign push  = link_in.stb;
    assign empty = (count == '0);

    // Head entry goes out as soon as the writer is free
    assign pop = !empty && !link_out.hold;

    // Pointers and occupancy
    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_rom) begin
        if (push) begin
            addr_mem[wr_ptr] <= link_in.word_addr;
            data_mem[wr_ptr] <= link_in.data;
            mask_mem[wr_ptr] <= link_in.mask;
        end
    end

    // Hold early, the last slot belongs to the entry already captured
    assign link_in.hold = (count >= (loader_pkg::FIFO_PW + 1)'(loader_pkg::FIFO_DEPTH - 1));

    assign link_out.stb       = pop;
    assign link_out.word_addr = addr_mem[rd_ptr];
    assign link_out.data      = data_mem[rd_ptr];
    assign link_out.mask      = mask_mem[rd_ptr];
    assign link_out.open      = link_in.open | !empty;

    // The spare slot must absorb any strobe that slips past hold
    assert property (@(posedge clk_rom) disable iff (!arst_n)
        push |-> (count != (loader_pkg::FIFO_PW + 1)'(loader_pkg::FIFO_DEPTH)))
        else $error("load FIFO overflow");

endmodule

/* logic/dwnld_capture.sv */
`timescale 1ns/1ps

module dwnld_capture (
    input  logic                   clk_rom,
    input  logic                   arst_n,
    input  logic                   hps_download,
    input  logic                   hps_wr,
    input  loader_pkg::dwnld_idx_t hps_index,
    input  loader_pkg::hps_addr_t  hps_addr,
    input  loader_pkg::hps_byte_t  hps_dout,
    output logic                   hps_wait,
    load_link_if.source            link
);

    logic                    keep;
    logic                    stb_r;
    logic                    dl_r;
    loader_pkg::sdram_addr_t addr_r;
    loader_pkg::hps_byte_t   data_r;
    loader_pkg::prog_mask_t  mask_r;

    // Only ROM bytes that fit in the programming space
    assign keep = hps_download && hps_wr
               && (hps_index == loader_pkg::ROM_INDEX)
               && (hps_addr < loader_pkg::ROM_BYTES);

    // Control path
    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            stb_r <= 1'b0;
            dl_r  <= 1'b0;
        end else begin
            stb_r <= keep;
            dl_r  <= hps_download;
        end
    end

    // Entry register, loaded on every kept byte
    always_ff @(posedge clk_rom) begin
        if (keep) begin
            addr_r <= hps_addr[loader_pkg::SDRAMW:1];
            data_r <= hps_dout;
            // Odd byte goes to the upper lane
            mask_r <= hps_addr[0] ? 2'b01 : 2'b10;
        end
    end

    assign link.stb       = stb_r;
    assign link.word_addr = addr_r;
    assign link.data      = data_r;
    assign link.mask      = mask_r;

    // Still open while the host loads or an entry sits here
    assign link.open = dl_r | stb_r;

    // The queue keeps one slot spare for the entry in this register,
    // so the host is paused straight from the queue level
    assign hps_wait = link.hold;

    // Host protocol, a write is never issued against wait
    assert property (@(posedge clk_rom) disable iff (!arst_n)
        hps_wait |-> !hps_wr)
        else $error("hps_wr strobed while hps_wait is high");

endmodule

/* logic/load_link_if.sv */
`timescale 1ns/1ps

// One programming byte moving between two loader stages
interface load_link_if;

    // Entry strobe, valid for a single cycle
    logic                    stb;
    loader_pkg::sdram_addr_t word_addr;
    loader_pkg::hps_byte_t   data;
    loader_pkg::prog_mask_t  mask;

    // Sink is busy, no new strobe allowed
    logic                    hold;

    // More entries may still come from upstream
    logic                    open;

    modport source (
        output stb, word_addr, data, mask, open,
        input  hold
    );

    modport sink (
        input  stb, word_addr, data, mask, open,
        output hold
    );

endinterface

/* logic/loader_pkg.sv */
package loader_pkg;

    // Host side byte address and programming word address widths
    localparam int HPS_AW = 27;
    localparam int SDRAMW = 22;

    // Load queue geometry
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PW    = 2;

    // Host download bus
    typedef logic [HPS_AW-1:0] hps_addr_t;
    typedef logic [7:0]        hps_byte_t;
    typedef logic [7:0]        dwnld_idx_t;

    // SDRAM programming port
    typedef logic [SDRAMW-1:0] sdram_addr_t;
    typedef logic [15:0]       prog_data_t;
    // Active low, bit 1 masks the upper byte
    typedef logic [1:0]        prog_mask_t;

    typedef logic [FIFO_PW-1:0] fifo_ptr_t;

    // File index used by the host for ROM data
    localparam dwnld_idx_t ROM_INDEX = 8'd0;

    // Bytes at or above this address do not fit in the programming space
    localparam hps_addr_t ROM_BYTES = hps_addr_t'(1) << (SDRAMW + 1);

    // Programming writer FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ISSUE,
        WR_WAIT
    } wr_state_e;

endpackage
